/* compile.f */
+incdir+sim
design/core_params_pkg.sv
design/rename_types_pkg.sv
design/alloc_pos_table.sv
design/free_list.sv
design/spec_map_table.sv
design/arch_map_table.sv
design/rename_unit.sv
sim/rename_unit_tb.sv

/* sim/rename_model.svh */
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

// reference copies of both maps
rename_types_pkg::ptag_t m_spec [core_params_pkg::ARCH_REG_NUM];
rename_types_pkg::ptag_t m_arch [core_params_pkg::ARCH_REG_NUM];
rename_types_pkg::ptag_t free_q [$]; // free tags, next grant at the front

// in-flight instructions, oldest at the front
rename_types_pkg::areg_t inf_dst_q [$];
rename_types_pkg::ptag_t inf_tag_q [$];
rename_types_pkg::ptag_t inf_old_q [$];

logic [15:0] lfsr_state;

// 16 bit Galois LFSR, maximal length taps
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

// one LFSR step per bit taken
function automatic logic [31:0] draw_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_state = lfsr_next(lfsr_state);
		v = {v[30:0], lfsr_state[0]};
	end
	return v;
endfunction

task automatic model_reset();
	free_q.delete();
	inf_dst_q.delete();
	inf_tag_q.delete();
	inf_old_q.delete();
	for (int r = 0; r < core_params_pkg::ARCH_REG_NUM; r++) begin
		m_spec[r] = rename_types_pkg::ptag_t'(r);
		m_arch[r] = rename_types_pkg::ptag_t'(r);
	end
	for (int i = 0; i < core_params_pkg::FL_ENTRY_NUM; i++) begin
		free_q.push_back(rename_types_pkg::ptag_t'(core_params_pkg::ARCH_REG_NUM + i));
	end
endtask

// index of the oldest allocating instruction left after nret retire, or -1
function automatic int oldest_squashed(input int nret);
	for (int i = nret; i < inf_tag_q.size(); i++) begin
		if (inf_tag_q[i] != '0) begin
			return i;
		end
	end
	return -1;
endfunction

// slots renamed in order on a scratch map, so slot 1 sees slot 0's write
task automatic model_predict();
	rename_types_pkg::ptag_t map [core_params_pkg::ARCH_REG_NUM];
	int nreq;
	int k;
	map = m_spec;
	nreq = 0;
	k = 0;
	for (int s = 0; s < core_params_pkg::RN_WIDTH; s++) begin
		if (rn_valid_i[s] && rn_dst_i[s] != '0) begin
			nreq++;
		end
	end
	exp_ready = !flush_i && (free_q.size() >= nreq);
	exp_cnt = rename_types_pkg::fl_cnt_t'(free_q.size());
	for (int s = 0; s < core_params_pkg::RN_WIDTH; s++) begin
		exp_src1[s] = map[rn_src1_i[s]];
		exp_src2[s] = map[rn_src2_i[s]];
		exp_old[s] = map[rn_dst_i[s]];
		exp_dst[s] = '0; // r0 keeps tag 0
		if (rn_valid_i[s] && rn_dst_i[s] != '0 && k < free_q.size()) begin
			exp_dst[s] = free_q[k];
			map[rn_dst_i[s]] = free_q[k];
			k++;
		end
	end
endtask

// state change at the rising edge
task automatic model_commit();
	rename_types_pkg::areg_t d;
	rename_types_pkg::ptag_t t;
	rename_types_pkg::ptag_t o;
	if (exp_ready) begin
		for (int s = 0; s < core_params_pkg::RN_WIDTH; s++) begin
			if (rn_valid_i[s]) begin
				if (rn_dst_i[s] != '0) begin
					void'(free_q.pop_front());
					m_spec[rn_dst_i[s]] = exp_dst[s];
				end
				inf_dst_q.push_back(rn_dst_i[s]);
				inf_tag_q.push_back(exp_dst[s]);
				inf_old_q.push_back(exp_old[s]);
			end
		end
	end
	for (int s = 0; s < core_params_pkg::RN_WIDTH; s++) begin
		if (rt_valid_i[s]) begin
			d = inf_dst_q.pop_front();
			t = inf_tag_q.pop_front();
			o = inf_old_q.pop_front();
			if (d != '0) begin
				m_arch[d] = t;
			end
			if (o != '0) begin
				free_q.push_back(o); // freed in retire order
			end
		end
	end
	if (flush_i) begin
		// squashed tags go back ahead of the free ones, oldest first
		for (int i = inf_tag_q.size() - 1; i >= 0; i--) begin
			if (inf_tag_q[i] != '0) begin
				free_q.push_front(inf_tag_q[i]);
			end
		end
		m_spec = m_arch;
		inf_dst_q.delete();
		inf_tag_q.delete();
		inf_old_q.delete();
	end
endtask

`endif

/* sim/rename_unit_tb.sv */
`timescale 1ns/1ps

module rename_unit_tb;

	logic clk_i;
	logic reset;
	logic [core_params_pkg::RN_WIDTH-1:0] rn_valid_i;
	rename_types_pkg::areg_t [core_params_pkg::RN_WIDTH-1:0] rn_dst_i;
	rename_types_pkg::areg_t [core_params_pkg::RN_WIDTH-1:0] rn_src1_i;
	rename_types_pkg::areg_t [core_params_pkg::RN_WIDTH-1:0] rn_src2_i;
	logic [core_params_pkg::RN_WIDTH-1:0] rt_valid_i;
	rename_types_pkg::areg_t [core_params_pkg::RN_WIDTH-1:0] rt_dst_i;
	rename_types_pkg::ptag_t [core_params_pkg::RN_WIDTH-1:0] rt_tag_i;
	rename_types_pkg::ptag_t [core_params_pkg::RN_WIDTH-1:0] rt_old_tag_i;
	logic flush_i;
	rename_types_pkg::ptag_t flush_tag_i;
	logic rn_ready_o;
	rename_types_pkg::ptag_t [core_params_pkg::RN_WIDTH-1:0] rn_src1_tag_o;
	rename_types_pkg::ptag_t [core_params_pkg::RN_WIDTH-1:0] rn_src2_tag_o;
	rename_types_pkg::ptag_t [core_params_pkg::RN_WIDTH-1:0] rn_dst_tag_o;
	rename_types_pkg::ptag_t [core_params_pkg::RN_WIDTH-1:0] rn_old_tag_o;
	rename_types_pkg::fl_cnt_t free_cnt_o;

	// expected values for the cycle on the bus
	logic exp_ready;
	rename_types_pkg::fl_cnt_t exp_cnt;
	rename_types_pkg::ptag_t [core_params_pkg::RN_WIDTH-1:0] exp_src1;
	rename_types_pkg::ptag_t [core_params_pkg::RN_WIDTH-1:0] exp_src2;
	rename_types_pkg::ptag_t [core_params_pkg::RN_WIDTH-1:0] exp_dst;
	rename_types_pkg::ptag_t [core_params_pkg::RN_WIDTH-1:0] exp_old;

	// next cycle's stimulus as set by the tests
	logic [core_params_pkg::RN_WIDTH-1:0] nx_valid;
	rename_types_pkg::areg_t [core_params_pkg::RN_WIDTH-1:0] nx_dst;
	rename_types_pkg::areg_t [core_params_pkg::RN_WIDTH-1:0] nx_src1;
	rename_types_pkg::areg_t [core_params_pkg::RN_WIDTH-1:0] nx_src2;
	int nx_ret;
	logic nx_flush;
	rename_types_pkg::areg_t ret_dst; // dst retired in the flush cycle

	logic chk_en;
	logic last_ready;
	string cur_test;
	int test_errs;
	int err_total;
	int tests_run;
	int tests_bad;

	`include "rename_model.svh"

	rename_unit dut_i (
		.clk_i         (clk_i),
		.reset         (reset),
		.rn_valid_i    (rn_valid_i),
		.rn_dst_i      (rn_dst_i),
		.rn_src1_i     (rn_src1_i),
		.rn_src2_i     (rn_src2_i),
		.rt_valid_i    (rt_valid_i),
		.rt_dst_i      (rt_dst_i),
		.rt_tag_i      (rt_tag_i),
		.rt_old_tag_i  (rt_old_tag_i),
		.flush_i       (flush_i),
		.flush_tag_i   (flush_tag_i),
		.rn_ready_o    (rn_ready_o),
		.rn_src1_tag_o (rn_src1_tag_o),
		.rn_src2_tag_o (rn_src2_tag_o),
		.rn_dst_tag_o  (rn_dst_tag_o),
		.rn_old_tag_o  (rn_old_tag_o),
		.free_cnt_o    (free_cnt_o)
	);

	initial begin
		clk_i = 1'b0;
		forever begin
			#10 clk_i = ~clk_i;
		end
	end

	function automatic void flag_mismatch(input string what, input logic [15:0] exp_v,
		input logic [15:0] act_v);
		test_errs++;
		$display("error in %s: %s expected %0h, actual %0h", cur_test, what, exp_v, act_v);
	endfunction

	assert property (@(posedge clk_i) disable iff (!chk_en) rn_ready_o == exp_ready)
		else flag_mismatch("rn_ready_o", $sampled(exp_ready), $sampled(rn_ready_o));
	assert property (@(posedge clk_i) disable iff (!chk_en) free_cnt_o == exp_cnt)
		else flag_mismatch("free_cnt_o", $sampled(exp_cnt), $sampled(free_cnt_o));
	// tags of a refused bundle carry no meaning
	assert property (@(posedge clk_i) disable iff (!chk_en)
		exp_ready |-> rn_src1_tag_o == exp_src1)
		else flag_mismatch("rn_src1_tag_o", $sampled(exp_src1), $sampled(rn_src1_tag_o));
	assert property (@(posedge clk_i) disable iff (!chk_en)
		exp_ready |-> rn_src2_tag_o == exp_src2)
		else flag_mismatch("rn_src2_tag_o", $sampled(exp_src2), $sampled(rn_src2_tag_o));
	assert property (@(posedge clk_i) disable iff (!chk_en)
		exp_ready |-> rn_dst_tag_o == exp_dst)
		else flag_mismatch("rn_dst_tag_o", $sampled(exp_dst), $sampled(rn_dst_tag_o));
	assert property (@(posedge clk_i) disable iff (!chk_en)
		exp_ready |-> rn_old_tag_o == exp_old)
		else flag_mismatch("rn_old_tag_o", $sampled(exp_old), $sampled(rn_old_tag_o));

	task automatic idle_bundle();
		nx_valid = '0;
		nx_dst = '0;
		nx_src1 = '0;
		nx_src2 = '0;
		nx_ret = 0;
		nx_flush = 1'b0;
	endtask

	task automatic rand_bundle(input logic [1:0] valid, input logic nonzero);
		nx_valid = valid;
		for (int s = 0; s < core_params_pkg::RN_WIDTH; s++) begin
			nx_dst[s] = rename_types_pkg::areg_t'(draw_bits(5));
			nx_src1[s] = rename_types_pkg::areg_t'(draw_bits(5));
			nx_src2[s] = rename_types_pkg::areg_t'(draw_bits(5));
			if (nonzero && nx_dst[s] == '0) begin
				nx_dst[s] = 5'd1;
			end
		end
	endtask

	// retirement always comes from the oldest in-flight instructions
	task automatic apply_inputs();
		int first;
		if (nx_ret > inf_dst_q.size()) begin
			nx_ret = inf_dst_q.size();
		end
		rn_valid_i = nx_valid;
		rn_dst_i = nx_dst;
		rn_src1_i = nx_src1;
		rn_src2_i = nx_src2;
		for (int s = 0; s < core_params_pkg::RN_WIDTH; s++) begin
			rt_valid_i[s] = (s < nx_ret);
			rt_dst_i[s] = (s < nx_ret) ? inf_dst_q[s] : '0;
			rt_tag_i[s] = (s < nx_ret) ? inf_tag_q[s] : '0;
			rt_old_tag_i[s] = (s < nx_ret) ? inf_old_q[s] : '0;
		end
		first = oldest_squashed(nx_ret);
		flush_i = nx_flush && (first >= 0); // needs an allocation in flight
		flush_tag_i = (first >= 0) ? inf_tag_q[first] : '0;
	endtask

	task automatic step();
		@(negedge clk_i);
		reset = 1'b0;
		apply_inputs();
		model_predict();
		chk_en = 1'b1;
		#5;
		last_ready = rn_ready_o;
		@(posedge clk_i);
		model_commit();
	endtask

	task automatic wait_ready(input int limit);
		int n;
		n = 0;
		step();
		while (!last_ready) begin
			n++;
			if (n >= limit) begin
				$display("%s: rn_ready_o stayed low for %0d cycles", cur_test, limit);
				test_errs++;
				return;
			end
			step();
		end
	endtask

	task automatic do_reset();
		@(negedge clk_i);
		chk_en = 1'b0;
		reset = 1'b1;
		idle_bundle();
		apply_inputs();
		repeat (2) @(posedge clk_i);
		model_reset();
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_errs = 0;
		do_reset();
	endtask

	task automatic finish_test();
		@(negedge clk_i); // lets the last edge's checks report first
		chk_en = 1'b0;
		tests_run++;
		err_total += test_errs;
		if (test_errs != 0) begin
			tests_bad++;
			$display("%s: %0d mismatches", cur_test, test_errs);
		end else begin
			$display("%s: all checks matched", cur_test);
		end
	endtask

	initial begin
		reset = 1'b1;
		chk_en = 1'b0;
		lfsr_state = 16'd61;
		tests_run = 0;
		tests_bad = 0;
		err_total = 0;
		ret_dst = '0;
		idle_bundle();
		rn_valid_i = '0;
		rn_dst_i = '0;
		rn_src1_i = '0;
		rn_src2_i = '0;
		rt_valid_i = '0;
		rt_dst_i = '0;
		rt_tag_i = '0;
		rt_old_tag_i = '0;
		flush_i = 1'b0;
		flush_tag_i = '0;

		begin_test("reset_state");
		step();
		nx_valid = 2'b11;
		nx_dst = {5'd7, 5'd5};
		nx_src1 = {5'd2, 5'd1};
		nx_src2 = {5'd4, 5'd3};
		step();
		finish_test();

		begin_test("bundle_bypass");
		nx_valid = 2'b11;
		nx_dst = {5'd12, 5'd9};
		nx_src1 = {5'd9, 5'd9};
		nx_src2 = {5'd9, 5'd6};
		step();
		nx_dst = {5'd10, 5'd0}; // r0 takes no tag
		nx_src1 = {5'd9, 5'd10};
		step();
		nx_dst = {5'd0, 5'd11};
		step();
		nx_dst = {5'd9, 5'd9}; // same dst twice
		step();
		finish_test();

		begin_test("ring_full");
		for (int i = 0; i < core_params_pkg::FL_ENTRY_NUM / 2; i++) begin
			rand_bundle(2'b11, 1'b1);
			step();
		end
		rand_bundle(2'b01, 1'b1);
		step();
		rand_bundle(2'b10, 1'b1);
		step();
		nx_ret = 1; // frees one tag while the bundle is still refused
		step();
		nx_ret = 0;
		wait_ready(4);
		nx_valid = '0;
		nx_ret = 2;
		step();
		nx_ret = 1;
		step();
		nx_ret = 0;
		rand_bundle(2'b11, 1'b1);
		step();
		rand_bundle(2'b01, 1'b1);
		step();
		finish_test();

		begin_test("random_traffic");
		rand_bundle(2'b11, 1'b0);
		nx_dst = '0;
		step();
		idle_bundle();
		nx_ret = 2; // old tags of 0 free nothing
		step();
		for (int i = 0; i < 300; i++) begin
			rand_bundle(2'(draw_bits(2)), 1'b0);
			nx_ret = draw_bits(2) % 3;
			step();
		end
		finish_test();

		begin_test("flush_restore");
		for (int i = 0; i < 6; i++) begin
			rand_bundle(2'b11, 1'b1);
			step();
		end
		rand_bundle(2'b11, 1'b1);
		nx_ret = 1;
		nx_flush = 1'b1;
		ret_dst = inf_dst_q[0];
		step();
		nx_ret = 0;
		nx_flush = 1'b0;
		rand_bundle(2'b11, 1'b1);
		nx_src1[0] = ret_dst; // mapping committed in the flush cycle
		step();
		for (int i = 0; i < 150; i++) begin
			rand_bundle(2'(draw_bits(2)), 1'b0);
			nx_ret = draw_bits(2) % 3;
			nx_flush = (draw_bits(4) == 0);
			step();
		end
		finish_test();

		$display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_bad, err_total);
		if (tests_bad == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* design/rename_unit.sv */
`timescale 1ns/1ps

module rename_unit (
	input  logic clk_i,
	input  logic reset,
	// rename bundle, slot 0 is older
	input  logic [core_params_pkg::RN_WIDTH-1:0] rn_valid_i,
	input  rename_types_pkg::areg_t [core_params_pkg::RN_WIDTH-1:0] rn_dst_i,
	input  rename_types_pkg::areg_t [core_params_pkg::RN_WIDTH-1:0] rn_src1_i,
	input  rename_types_pkg::areg_t [core_params_pkg::RN_WIDTH-1:0] rn_src2_i,
	// retirement
	input  logic [core_params_pkg::RN_WIDTH-1:0] rt_valid_i,
	input  rename_types_pkg::areg_t [core_params_pkg::RN_WIDTH-1:0] rt_dst_i,
	input  rename_types_pkg::ptag_t [core_params_pkg::RN_WIDTH-1:0] rt_tag_i,
	input  rename_types_pkg::ptag_t [core_params_pkg::RN_WIDTH-1:0] rt_old_tag_i,
	input  logic flush_i,
	input  rename_types_pkg::ptag_t flush_tag_i, // dst tag of oldest squashed instr
	output logic rn_ready_o,
	output rename_types_pkg::ptag_t [core_params_pkg::RN_WIDTH-1:0] rn_src1_tag_o,
	output rename_types_pkg::ptag_t [core_params_pkg::RN_WIDTH-1:0] rn_src2_tag_o,
	output rename_types_pkg::ptag_t [core_params_pkg::RN_WIDTH-1:0] rn_dst_tag_o,
	output rename_types_pkg::ptag_t [core_params_pkg::RN_WIDTH-1:0] rn_old_tag_o,
	output rename_types_pkg::fl_cnt_t free_cnt_o
);

	logic [core_params_pkg::RN_WIDTH-1:0] alloc_req;
	logic alloc_ok;
	rename_types_pkg::ptag_t [core_params_pkg::RN_WIDTH-1:0] alloc_tag;
	rename_types_pkg::ptag_t [core_params_pkg::ARCH_REG_NUM-1:0] arch_map_next;

	assign rn_ready_o = alloc_ok;

	spec_map_table spec_map_i (
		.clk_i       (clk_i),
		.reset       (reset),
		.flush_i     (flush_i),
		.rn_valid_i  (rn_valid_i),
		.rn_dst_i    (rn_dst_i),
		.rn_src1_i   (rn_src1_i),
		.rn_src2_i   (rn_src2_i),
		.alloc_ok_i  (alloc_ok),
		.alloc_tag_i (alloc_tag),
		.arch_map_i  (arch_map_next),
		.alloc_req_o (alloc_req),
		.src1_tag_o  (rn_src1_tag_o),
		.src2_tag_o  (rn_src2_tag_o),
		.dst_tag_o   (rn_dst_tag_o),
		.old_tag_o   (rn_old_tag_o)
	);

	arch_map_table arch_map_i (
		.clk_i           (clk_i),
		.reset           (reset),
		.rt_valid_i      (rt_valid_i),
		.rt_dst_i        (rt_dst_i),
		.rt_tag_i        (rt_tag_i),
		.arch_map_next_o (arch_map_next)
	);

	free_list free_list_i (
		.clk_i        (clk_i),
		.reset        (reset),
		.flush_i      (flush_i),
		.flush_tag_i  (flush_tag_i),
		.alloc_req_i  (alloc_req),
		.rt_valid_i   (rt_valid_i),
		.rt_old_tag_i (rt_old_tag_i),
		.alloc_ok_o   (alloc_ok),
		.alloc_tag_o  (alloc_tag),
		.free_cnt_o   (free_cnt_o)
	);

endmodule

/* design/arch_map_table.sv */
`timescale 1ns/1ps

module arch_map_table (
	input  logic clk_i,
	input  logic reset,
	input  logic [core_params_pkg::RN_WIDTH-1:0] rt_valid_i,
	input  rename_types_pkg::areg_t [core_params_pkg::RN_WIDTH-1:0] rt_dst_i,
	input  rename_types_pkg::ptag_t [core_params_pkg::RN_WIDTH-1:0] rt_tag_i,
	output rename_types_pkg::ptag_t [core_params_pkg::ARCH_REG_NUM-1:0] arch_map_next_o
);

	// committed mapping
	rename_types_pkg::ptag_t [core_params_pkg::ARCH_REG_NUM-1:0] arch_map;

	// next state is visible so a flush this cycle picks up this cycle's retirements
	always_comb begin
		arch_map_next_o = arch_map;
		for (int s = 0; s < core_params_pkg::RN_WIDTH; s++) begin
			if (rt_valid_i[s] && rt_dst_i[s] != '0) begin
				arch_map_next_o[rt_dst_i[s]] = rt_tag_i[s]; // younger slot wins
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset) begin
			for (int r = 0; r < core_params_pkg::ARCH_REG_NUM; r++) begin
				arch_map[r] <= rename_types_pkg::ptag_t'(r);
			end
		end else begin
			arch_map <= arch_map_next_o;
		end
	end

endmodule

/* design/spec_map_table.sv */
`timescale 1ns/1ps

module spec_map_table (
	input  logic clk_i,
	input  logic reset,
	input  logic flush_i,
	input  logic [core_params_pkg::RN_WIDTH-1:0] rn_valid_i,
	input  rename_types_pkg::areg_t [core_params_pkg::RN_WIDTH-1:0] rn_dst_i,
	input  rename_types_pkg::areg_t [core_params_pkg::RN_WIDTH-1:0] rn_src1_i,
	input  rename_types_pkg::areg_t [core_params_pkg::RN_WIDTH-1:0] rn_src2_i,
	input  logic alloc_ok_i,
	input  rename_types_pkg::ptag_t [core_params_pkg::RN_WIDTH-1:0] alloc_tag_i,
	input  rename_types_pkg::ptag_t [core_params_pkg::ARCH_REG_NUM-1:0] arch_map_i,
	output logic [core_params_pkg::RN_WIDTH-1:0] alloc_req_o,
	output rename_types_pkg::ptag_t [core_params_pkg::RN_WIDTH-1:0] src1_tag_o,
	output rename_types_pkg::ptag_t [core_params_pkg::RN_WIDTH-1:0] src2_tag_o,
	output rename_types_pkg::ptag_t [core_params_pkg::RN_WIDTH-1:0] dst_tag_o,
	output rename_types_pkg::ptag_t [core_params_pkg::RN_WIDTH-1:0] old_tag_o
);

	// speculative arch to phys mapping, entry 0 stays at tag 0
	rename_types_pkg::ptag_t [core_params_pkg::ARCH_REG_NUM-1:0] spec_map;

	always_comb begin
		for (int s = 0; s < core_params_pkg::RN_WIDTH; s++) begin
			alloc_req_o[s] = rn_valid_i[s] && (rn_dst_i[s] != '0); // r0 is never renamed
		end
	end

	// lookups, then override by older slots writing the same reg
	always_comb begin
		for (int s = 0; s < core_params_pkg::RN_WIDTH; s++) begin
			src1_tag_o[s] = spec_map[rn_src1_i[s]];
			src2_tag_o[s] = spec_map[rn_src2_i[s]];
			old_tag_o[s] = spec_map[rn_dst_i[s]];
			for (int j = 0; j < s; j++) begin
				if (alloc_req_o[j] && rn_dst_i[j] == rn_src1_i[s]) begin
					src1_tag_o[s] = alloc_tag_i[j];
				end
				if (alloc_req_o[j] && rn_dst_i[j] == rn_src2_i[s]) begin
					src2_tag_o[s] = alloc_tag_i[j];
				end
				if (alloc_req_o[j] && rn_dst_i[j] == rn_dst_i[s]) begin
					old_tag_o[s] = alloc_tag_i[j]; // prior writer in the bundle
				end
			end
			dst_tag_o[s] = alloc_req_o[s] ? alloc_tag_i[s] : '0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset) begin
			for (int r = 0; r < core_params_pkg::ARCH_REG_NUM; r++) begin
				spec_map[r] <= rename_types_pkg::ptag_t'(r); // identity map
			end
		end else if (flush_i) begin
			spec_map <= arch_map_i; // full squash back to committed state
		end else if (alloc_ok_i) begin
			// later slot overwrites on the same destination
			for (int s = 0; s < core_params_pkg::RN_WIDTH; s++) begin
				if (alloc_req_o[s]) begin
					spec_map[rn_dst_i[s]] <= alloc_tag_i[s];
				end
			end
		end
	end

endmodule

/* design/free_list.sv */
`timescale 1ns/1ps

module free_list (
	input  logic clk_i,
	input  logic reset,
	input  logic flush_i,
	input  rename_types_pkg::ptag_t flush_tag_i,
	input  logic [core_params_pkg::RN_WIDTH-1:0] alloc_req_i,
	input  logic [core_params_pkg::RN_WIDTH-1:0] rt_valid_i,
	input  rename_types_pkg::ptag_t [core_params_pkg::RN_WIDTH-1:0] rt_old_tag_i,
	output logic alloc_ok_o,
	output rename_types_pkg::ptag_t [core_params_pkg::RN_WIDTH-1:0] alloc_tag_o,
	output rename_types_pkg::fl_cnt_t free_cnt_o
);

	rename_types_pkg::ptag_t ring [core_params_pkg::FL_ENTRY_NUM];

	rename_types_pkg::fl_ptr_t rd_ptr; // next tag to hand out
	rename_types_pkg::fl_ptr_t rd_ptr_next;
	rename_types_pkg::fl_ptr_t wr_ptr; // next slot for a freed tag
	rename_types_pkg::fl_ptr_t wr_ptr_next;
	rename_types_pkg::fl_ptr_t restore_pos;

	rename_types_pkg::fl_ptr_t [core_params_pkg::RN_WIDTH-1:0] grant_pos;
	rename_types_pkg::fl_ptr_t [core_params_pkg::RN_WIDTH-1:0] push_pos;
	logic [core_params_pkg::RN_WIDTH-1:0] grant_en;
	logic [core_params_pkg::RN_WIDTH-1:0] push_en;
	rename_types_pkg::fl_cnt_t req_num;

	// entry select, wrap bit dropped
	function automatic logic [$bits(rename_types_pkg::fl_ptr_t)-2:0] ring_idx(
		input rename_types_pkg::fl_ptr_t ptr
	);
		return ptr[$bits(rename_types_pkg::fl_ptr_t)-2:0];
	endfunction

	// read side, a slot without a request does not consume a position
	always_comb begin
		rename_types_pkg::fl_ptr_t pos;
		pos = rd_ptr;
		req_num = '0;
		for (int s = 0; s < core_params_pkg::RN_WIDTH; s++) begin
			grant_pos[s] = pos;
			alloc_tag_o[s] = ring[ring_idx(pos)];
			if (alloc_req_i[s]) begin
				pos = pos + 1'b1;
				req_num = req_num + 1'b1;
			end
		end
	end

	assign free_cnt_o = wr_ptr - rd_ptr; // wrap bit tells full from empty

	// whole bundle or nothing
	assign alloc_ok_o = !flush_i && (free_cnt_o >= req_num);
	assign grant_en = alloc_req_i & {core_params_pkg::RN_WIDTH{alloc_ok_o}};

	// write side, retired old tags packed in slot order
	always_comb begin
		rename_types_pkg::fl_ptr_t pos;
		pos = wr_ptr;
		for (int s = 0; s < core_params_pkg::RN_WIDTH; s++) begin
			push_en[s] = rt_valid_i[s] && (rt_old_tag_i[s] != '0); // tag 0 never freed
			push_pos[s] = pos;
			if (push_en[s]) begin
				pos = pos + 1'b1;
			end
		end
		wr_ptr_next = pos;
	end

	always_comb begin
		if (flush_i) begin
			rd_ptr_next = restore_pos; // squashed tags become free again
		end else if (alloc_ok_o) begin
			rd_ptr_next = rd_ptr + rename_types_pkg::fl_ptr_t'(req_num);
		end else begin
			rd_ptr_next = rd_ptr;
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= rename_types_pkg::fl_ptr_t'(core_params_pkg::FL_ENTRY_NUM);
			// ring starts full with the tags above the arch range
			for (int i = 0; i < core_params_pkg::FL_ENTRY_NUM; i++) begin
				ring[i] <= rename_types_pkg::ptag_t'(core_params_pkg::ARCH_REG_NUM + i);
			end
		end else begin
			rd_ptr <= rd_ptr_next;
			wr_ptr <= wr_ptr_next;
			for (int s = 0; s < core_params_pkg::RN_WIDTH; s++) begin
				if (push_en[s]) begin
					ring[ring_idx(push_pos[s])] <= rt_old_tag_i[s];
				end
			end
		end
	end

	alloc_pos_table pos_table_i (
		.clk_i    (clk_i),
		.reset    (reset),
		.wr_en_i  (grant_en),
		.wr_tag_i (alloc_tag_o),
		.wr_pos_i (grant_pos),
		.rd_tag_i (flush_tag_i),
		.rd_pos_o (restore_pos)
	);

endmodule

/* design/alloc_pos_table.sv */
`timescale 1ns/1ps

module alloc_pos_table (
	input  logic clk_i,
	input  logic reset,
	input  logic [core_params_pkg::RN_WIDTH-1:0] wr_en_i,
	input  rename_types_pkg::ptag_t [core_params_pkg::RN_WIDTH-1:0] wr_tag_i,
	input  rename_types_pkg::fl_ptr_t [core_params_pkg::RN_WIDTH-1:0] wr_pos_i,
	input  rename_types_pkg::ptag_t rd_tag_i,
	output rename_types_pkg::fl_ptr_t rd_pos_o
);

	// ring position each tag was last granted from
	rename_types_pkg::fl_ptr_t pos_tab [core_params_pkg::PHY_REG_NUM];

	always_ff @(posedge clk_i) begin
		if (reset) begin
			for (int t = 0; t < core_params_pkg::PHY_REG_NUM; t++) begin
				pos_tab[t] <= '0;
			end
		end else begin
			// granted tags in one bundle are always distinct
			for (int s = 0; s < core_params_pkg::RN_WIDTH; s++) begin
				if (wr_en_i[s]) begin
					pos_tab[wr_tag_i[s]] <= wr_pos_i[s];
				end
			end
		end
	end

	// read pointer rewinds to where the oldest squashed tag sat
	assign rd_pos_o = pos_tab[rd_tag_i];

endmodule

/* design/rename_types_pkg.sv */
package rename_types_pkg;

	// architectural register index
	typedef logic [$clog2(core_params_pkg::ARCH_REG_NUM)-1:0] areg_t;

	// physical register tag
	typedef logic [$clog2(core_params_pkg::PHY_REG_NUM)-1:0] ptag_t;

	// free ring position, top bit is the wrap bit
	typedef logic [$clog2(core_params_pkg::FL_ENTRY_NUM):0] fl_ptr_t;

	// number of free tags, 0 up to a full ring
	typedef logic [$clog2(core_params_pkg::FL_ENTRY_NUM+1)-1:0] fl_cnt_t;

endpackage

/* design/core_params_pkg.sv */
package core_params_pkg;

	// architectural register file as seen by software
	localparam int ARCH_REG_NUM = 32;

	// physical register file, tag 0 reserved for arch reg 0
	localparam int PHY_REG_NUM = 64;

	// tags not held by the retirement map sit in the free ring
	localparam int FL_ENTRY_NUM = PHY_REG_NUM - ARCH_REG_NUM;

	localparam int RN_WIDTH = 2; // rename and retire slots per cycle

endpackage
